// ==== sim.f ====
hw/touch_pkg.sv
hw/touch_irq_detect.sv
hw/touch_read_sequencer.sv
hw/i2c_bit_engine.sv
hw/touch_i2c_top.sv
tb/touch_panel_model.sv
tb/touch_i2c_checker.sv
tb/touch_i2c_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f sim.f \
    --top-module touch_i2c_tb -Mdir obj_dir -o touch_i2c_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/touch_i2c_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== tb/touch_i2c_tb.sv ====
module touch_i2c_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int FRAMES = 13;   // Frames started over all tests
    localparam int LIMIT  = (FRAMES + 2) * touch_pkg::CMDS_PER_FRAME
                            * (touch_pkg::PHASES_PER_BIT + 1) * 2;

    logic        clk;
    logic        nRst;
    logic        inter;
    logic        sda_in;
    logic        scl;
    logic        sda_out;
    logic        sda_oeb;
    logic        done;
    logic [31:0] data_out;
    logic [7:0]  xh;
    logic [7:0]  xl;
    logic [7:0]  yh;
    logic [7:0]  yl;
    logic [31:0] lcg_state;
    logic [31:0] exp_q[$];

    int wr_count;
    int rd_count;
    int proto_err;
    int checks     = 0;
    int errors     = 0;
    int cmp_checks = 0;
    int cmp_errors = 0;
    int done_cnt   = 0;
    int exp_idx    = 0;

    touch_i2c_top u_dut (
        .clk      (clk),
        .nRst     (nRst),
        .inter    (inter),
        .sda_in   (sda_in),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oeb  (sda_oeb),
        .data_out (data_out),
        .done     (done)
    );

    touch_panel_model u_panel (
        .clk       (clk),
        .nRst      (nRst),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oeb   (sda_oeb),
        .xh_val    (xh),
        .xl_val    (xl),
        .yh_val    (yh),
        .yl_val    (yl),
        .sda_in    (sda_in),
        .wr_count  (wr_count),
        .rd_count  (rd_count),
        .proto_err (proto_err)
    );

    bind touch_i2c_top touch_i2c_checker u_checker (
        .clk       (clk),
        .nRst      (nRst),
        .inter     (inter),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oeb   (sda_oeb),
        .done      (done),
        .seq_state (u_seq.state)
    );

    // Byte lanes: XH lowest, YL highest
    function automatic logic [31:0] expected_word(input logic [7:0] x_hi, input logic [7:0] x_lo,
                                                  input logic [7:0] y_hi, input logic [7:0] y_lo);
        return {y_lo, y_hi, x_lo, x_hi};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] v;
        v = lcg_next();
        return v[23:16];   // Upper bits, low ones repeat quickly
    endfunction

    function automatic int total_errors();
        return errors + cmp_errors;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        int cyc;
        cyc = 0;
        while (cyc < LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        $display("Timeout after %0d cycles, frames did not finish", cyc);
        $display("Test failed");
        $finish;
    end

    always @(negedge clk) begin : compare_frames
        logic [31:0] want;
        if (nRst && done) begin
            done_cnt++;
            cmp_checks++;
            if (exp_idx >= exp_q.size()) begin
                cmp_errors++;
                $display("[ERROR] %0t: done pulse with no frame expected", $time);
            end else begin
                want = exp_q[exp_idx];
                exp_idx++;
                assert (data_out == want) else begin
                    cmp_errors++;
                    $display("[ERROR] %0t: data_out %08h, expected %08h", $time, data_out, want);
                end
            end
        end
    end

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t: %s", $time, msg);
        end
    endtask

    // Bus idle and outputs frozen for n cycles
    task automatic hold_idle(input int n, input logic [31:0] word, input string msg);
        logic bad;
        bad = 1'b0;
        repeat (n) begin
            @(negedge clk);
            if (!scl || !sda_out || sda_oeb || done || data_out !== word) begin
                bad = 1'b1;
            end
        end
        check(!bad, msg);
    endtask

    task automatic load_frame(input logic [7:0] x_hi, input logic [7:0] x_lo,
                              input logic [7:0] y_hi, input logic [7:0] y_lo);
        xh = x_hi;
        xl = x_lo;
        yh = y_hi;
        yl = y_lo;
        exp_q.push_back(expected_word(x_hi, x_lo, y_hi, y_lo));
    endtask

    task automatic touch();
        @(negedge clk);
        inter = 1'b0;
        repeat (4) @(negedge clk);
        inter = 1'b1;
    endtask

    task automatic wait_done(input int target);
        wait (done_cnt >= target);
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("%s: %0d errors", name, total_errors() - err_mark);
    endtask

    initial begin : stimulus
        int base;
        int err_mark;
        nRst      = 1'b0;
        inter     = 1'b1;
        lcg_state = 32'd51;
        xh        = 8'h00;
        xl        = 8'h00;
        yh        = 8'h00;
        yl        = 8'h00;
        repeat (8) @(negedge clk);
        nRst = 1'b1;

        err_mark = total_errors();
        hold_idle(200, 32'd0, "bus or outputs moved without a touch");
        check(done_cnt == 0, "done seen without a touch");
        report_test("reset_state", err_mark);

        err_mark = total_errors();
        load_frame(8'h12, 8'h34, 8'h56, 8'h78);
        touch();
        wait_done(1);
        hold_idle(200, expected_word(8'h12, 8'h34, 8'h56, 8'h78),
                  "second frame started or data_out changed after one touch");
        check(done_cnt == 1, "more than one done for one touch");
        check(wr_count == 4 && rd_count == 4, "wrong transaction count for one frame");
        report_test("single_touch", err_mark);

        err_mark = total_errors();
        base = done_cnt;
        for (int i = 0; i < 10; i++) begin
            load_frame(rand_byte(), rand_byte(), rand_byte(), rand_byte());
            touch();
            wait_done(base + i + 1);
        end
        report_test("random_frames", err_mark);

        err_mark = total_errors();
        base = done_cnt;
        load_frame(8'hc3, 8'h5a, 8'h0f, 8'he1);
        exp_q.push_back(expected_word(xh, xl, yh, yl));   // Queued repeat of the same values
        touch();
        wait (rd_count >= 4 * base + 2);
        touch();
        repeat (20) @(negedge clk);
        touch();
        wait_done(base + 2);
        hold_idle(200, expected_word(8'hc3, 8'h5a, 8'h0f, 8'he1),
                  "third touch in one frame started an extra frame");
        check(done_cnt == base + 2, "touches during a frame gave the wrong frame count");
        report_test("touch_in_frame", err_mark);

        err_mark = total_errors();
        check(wr_count == 4 * done_cnt, "write transaction count does not match frames");
        check(rd_count == 4 * done_cnt, "read transaction count does not match frames");
        check(proto_err == 0, "panel model saw bad order, missing NACK or missing stop");
        report_test("bus_protocol", err_mark);

        $display("checks: %0d, errors: %0d", checks + cmp_checks, total_errors());
        if (total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/touch_i2c_checker.sv ====
module touch_i2c_checker (
    input logic                  clk,
    input logic                  nRst,
    input logic                  inter,
    input logic                  scl,
    input logic                  sda_out,
    input logic                  sda_oeb,
    input logic                  done,
    input touch_pkg::seq_state_t seq_state
);
    timeunit 1ns;
    timeprecision 1ns;

    logic inter_q;
    logic touched;   // A falling edge of inter has been seen

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            inter_q <= 1'b1;
            touched <= 1'b0;
        end else begin
            inter_q <= inter;
            if (inter_q && !inter) begin
                touched <= 1'b1;
            end
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!nRst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    oeb_released: assert property (@(posedge clk) disable iff (!nRst) sda_oeb |-> sda_out)
        else $error("sda_out driven low while sda_oeb is set");

    done_after_touch: assert property (@(posedge clk) disable iff (!nRst) done |-> touched)
        else $error("done without any falling edge of inter");

    idle_bus_high: assert property (@(posedge clk) disable iff (!nRst)
        (seq_state == touch_pkg::IDLE) |-> (scl && sda_out))
        else $error("bus lines not released while the sequencer is idle");

endmodule

// ==== tb/touch_panel_model.sv ====
module touch_panel_model (
    input  logic       clk,
    input  logic       nRst,
    input  logic       scl,
    input  logic       sda_out,
    input  logic       sda_oeb,
    input  logic [7:0] xh_val,
    input  logic [7:0] xl_val,
    input  logic [7:0] yh_val,
    input  logic [7:0] yl_val,
    output logic       sda_in,
    output int         wr_count,
    output int         rd_count,
    output int         proto_err
);
    timeunit 1ns;
    timeprecision 1ns;

    touch_pkg::reg_addr_t reg_ptr;
    touch_pkg::reg_addr_t wr_expect;
    touch_pkg::reg_addr_t rd_expect;

    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [3:0] bit_cnt;     // Clocks finished in the current byte
    logic [1:0] stage;       // 0 address, 1 pointer, 2 data out, 3 inactive
    logic       is_read;
    logic       fresh;       // First scl fall after a start carries no bit
    logic       want_stop;
    logic       scl_q;
    logic       sda_q;
    logic       sda_drv;

    function automatic logic [7:0] reg_value(input touch_pkg::reg_addr_t addr);
        case (addr)
            touch_pkg::XH: return xh_val;
            touch_pkg::XL: return xl_val;
            touch_pkg::YH: return yh_val;
            touch_pkg::YL: return yl_val;
            default:       return 8'hff;
        endcase
    endfunction

    function automatic touch_pkg::reg_addr_t next_reg(input touch_pkg::reg_addr_t addr);
        if (addr == touch_pkg::YL) begin
            return touch_pkg::XH;
        end
        return touch_pkg::reg_addr_t'(addr + 8'd1);
    endfunction

    assign sda_in  = !nRst || sda_drv;   // Open drain, released while in reset
    assign tx_byte = reg_value(reg_ptr);

    // Bus sampled mid-cycle where the DUT lines are stable
    always @(negedge clk) begin
        if (!nRst) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            sda_drv   <= 1'b1;
            shift     <= 8'd0;
            bit_cnt   <= 4'd0;
            stage     <= 2'd3;
            is_read   <= 1'b0;
            fresh     <= 1'b0;
            want_stop <= 1'b0;
            reg_ptr   <= touch_pkg::XH;
            wr_expect <= touch_pkg::XH;
            rd_expect <= touch_pkg::XH;
            wr_count  <= 0;
            rd_count  <= 0;
            proto_err <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda_out;
            if (scl && scl_q && sda_q && !sda_out) begin   // Start or repeated start
                if (want_stop) begin
                    proto_err <= proto_err + 1;
                end
                bit_cnt <= 4'd0;
                stage   <= 2'd0;
                fresh   <= 1'b1;
            end else if (scl && scl_q && !sda_q && sda_out) begin   // Stop
                stage     <= 2'd3;
                want_stop <= 1'b0;
                sda_drv   <= 1'b1;
            end else if (!scl_q && scl && !fresh) begin
                if (bit_cnt < 4'd8 && stage < 2'd2) begin
                    shift <= {shift[6:0], sda_out};
                end
                if (bit_cnt == 4'd8 && stage == 2'd2) begin
                    // Master answer to a read byte must be a NACK
                    rd_count  <= rd_count + 1;
                    rd_expect <= next_reg(rd_expect);
                    want_stop <= 1'b1;
                    if (reg_ptr != rd_expect || !sda_out || sda_oeb) begin
                        proto_err <= proto_err + 1;
                    end
                end
            end else if (scl_q && !scl && stage != 2'd3) begin
                if (fresh) begin
                    fresh <= 1'b0;
                end else if (bit_cnt == 4'd7) begin
                    bit_cnt <= 4'd8;
                    case (stage)
                        2'd0: begin
                            is_read <= shift[0];
                            sda_drv <= 1'b0;
                            if (shift[7:1] != touch_pkg::SLAVE_ADDR) begin
                                proto_err <= proto_err + 1;
                            end
                        end
                        2'd1: begin
                            reg_ptr   <= touch_pkg::reg_addr_t'(shift);
                            wr_count  <= wr_count + 1;
                            wr_expect <= next_reg(wr_expect);
                            sda_drv   <= 1'b0;
                            if (shift != wr_expect) begin
                                proto_err <= proto_err + 1;
                            end
                        end
                        default: sda_drv <= 1'b1;   // Master ack slot
                    endcase
                end else if (bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd0;
                    if (stage == 2'd0 && is_read) begin
                        stage   <= 2'd2;
                        sda_drv <= tx_byte[7];
                    end else if (stage == 2'd0) begin
                        stage   <= 2'd1;
                        sda_drv <= 1'b1;
                    end else begin
                        stage   <= 2'd3;   // Single byte only, no burst
                        sda_drv <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (stage == 2'd2) begin
                        sda_drv <= tx_byte[3'(4'd6 - bit_cnt)];
                    end
                end
            end
        end
    end

endmodule

// ==== hw/touch_i2c_top.sv ====
module touch_i2c_top (
    input  logic        clk,
    input  logic        nRst,
    input  logic        inter,
    input  logic        sda_in,
    output logic        scl,
    output logic        sda_out,
    output logic        sda_oeb,
    output logic [31:0] data_out,
    output logic        done
);

    touch_pkg::bus_cmd_t cmd;

    logic pending;
    logic take;
    logic sda_sync;
    logic cmd_strobe;
    logic wr_bit;
    logic bit_done;
    logic rd_bit;

    touch_irq_detect u_irq (
        .clk      (clk),
        .nRst     (nRst),
        .inter    (inter),
        .sda_in   (sda_in),
        .take     (take),
        .pending  (pending),
        .sda_sync (sda_sync)
    );

    touch_read_sequencer u_seq (
        .clk        (clk),
        .nRst       (nRst),
        .pending    (pending),
        .take       (take),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .wr_bit     (wr_bit),
        .bit_done   (bit_done),
        .rd_bit     (rd_bit),
        .data_out   (data_out),
        .done       (done)
    );

    i2c_bit_engine u_bit (
        .clk        (clk),
        .nRst       (nRst),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .wr_bit     (wr_bit),
        .sda_sync   (sda_sync),
        .bit_done   (bit_done),
        .rd_bit     (rd_bit),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oeb    (sda_oeb)
    );

endmodule

// ==== hw/i2c_bit_engine.sv ====
module i2c_bit_engine (
    input  logic                clk,
    input  logic                nRst,
    input  logic                cmd_strobe,
    input  touch_pkg::bus_cmd_t cmd,
    input  logic                wr_bit,
    input  logic                sda_sync,
    output logic                bit_done,
    output logic                rd_bit,
    output logic                scl,
    output logic                sda_out,
    output logic                sda_oeb
);

    localparam logic [1:0] LAST_PHASE = 2'(touch_pkg::PHASES_PER_BIT - 1);

    touch_pkg::bus_cmd_t cmd_q, act_cmd;
    logic [1:0] phase, next_phase;
    logic       busy;
    logic       launch;
    logic       ending;
    logic       scl_n, sda_out_n, sda_oeb_n;

    assign launch     = cmd_strobe && !busy;
    assign ending     = busy && (phase == LAST_PHASE);
    assign act_cmd    = launch ? cmd : cmd_q;
    assign next_phase = launch ? 2'd0 : phase + 2'd1;

    always_comb begin : line_levels
        scl_n     = scl;
        sda_out_n = sda_out;
        sda_oeb_n = sda_oeb;
        if (ending) begin
            scl_n     = (cmd_q == touch_pkg::CMD_STOP);   // Bus free only after a stop
            sda_oeb_n = 1'b0;
            if (cmd_q == touch_pkg::CMD_READ) begin
                sda_out_n = 1'b1;
            end
        end else if (launch || busy) begin
            case (act_cmd)
                touch_pkg::CMD_START: begin
                    if (next_phase == 2'd0) begin
                        sda_out_n = 1'b0;   // Falls while scl is high
                        sda_oeb_n = 1'b0;
                    end else begin
                        scl_n = 1'b0;
                    end
                end
                touch_pkg::CMD_STOP: begin
                    case (next_phase)
                        2'd0: begin
                            sda_out_n = 1'b0;
                            sda_oeb_n = 1'b0;
                        end
                        2'd1:    scl_n     = 1'b1;
                        default: sda_out_n = 1'b1;   // Rises while scl is high
                    endcase
                end
                default: begin
                    if (next_phase == 2'd0) begin
                        scl_n     = 1'b0;
                        sda_out_n = (act_cmd == touch_pkg::CMD_WRITE) ? wr_bit : 1'b1;
                        sda_oeb_n = (act_cmd == touch_pkg::CMD_READ);
                    end else begin
                        scl_n = 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            phase    <= 2'd0;
            busy     <= 1'b0;
            bit_done <= 1'b0;
            scl      <= 1'b1;
            sda_out  <= 1'b1;
            sda_oeb  <= 1'b0;
        end else begin
            scl      <= scl_n;
            sda_out  <= sda_out_n;
            sda_oeb  <= sda_oeb_n;
            bit_done <= busy && (phase == LAST_PHASE - 2'd1);
            if (launch) begin
                busy  <= 1'b1;
                phase <= 2'd0;
            end else if (ending) begin
                busy <= 1'b0;
            end else if (busy) begin
                phase <= next_phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_q <= cmd;
        end
        if (busy && phase == LAST_PHASE - 2'd1) begin
            rd_bit <= sda_sync;   // Sampled mid-high of scl
        end
    end

endmodule

// ==== hw/touch_read_sequencer.sv ====
module touch_read_sequencer (
    input  logic                clk,
    input  logic                nRst,
    input  logic                pending,
    output logic                take,
    output logic                cmd_strobe,
    output touch_pkg::bus_cmd_t cmd,
    output logic                wr_bit,
    input  logic                bit_done,
    input  logic                rd_bit,
    output logic [31:0]         data_out,
    output logic                done
);

    touch_pkg::seq_state_t state, state_n;
    touch_pkg::reg_addr_t  reg_addr, reg_n;
    touch_pkg::bus_cmd_t   cmd_n;

    logic [3:0]  bit_cnt, cnt_n;
    logic [3:0]  last_cnt;
    logic [7:0]  tx_byte;
    logic [1:0]  lane;
    logic [31:0] shadow;
    logic        issue;
    logic        finish;
    logic        bit_n;

    assign last_cnt = (state == touch_pkg::READ_BYTE) ? 4'd7 : 4'd8;   // No ack slot in a read
    assign lane     = 2'(reg_addr - touch_pkg::XH);

    always_comb begin : next_step
        state_n = state;
        cnt_n   = bit_cnt;
        reg_n   = reg_addr;
        issue   = 1'b0;
        finish  = 1'b0;
        case (state)
            touch_pkg::IDLE: begin
                if (pending) begin
                    state_n = touch_pkg::START_WR;
                    cnt_n   = 4'd0;
                    reg_n   = touch_pkg::XH;
                    issue   = 1'b1;
                end
            end
            touch_pkg::STOP_RD: begin
                if (bit_done) begin
                    if (reg_addr == touch_pkg::YL) begin
                        state_n = touch_pkg::IDLE;   // Frame complete
                        finish  = 1'b1;
                    end else begin
                        state_n = touch_pkg::START_WR;
                        reg_n   = touch_pkg::reg_addr_t'(reg_addr + 8'd1);
                        issue   = 1'b1;
                    end
                end
            end
            touch_pkg::SLAVE_ADDR_WR, touch_pkg::REG_ADDR,
            touch_pkg::SLAVE_ADDR_RD, touch_pkg::READ_BYTE: begin
                if (bit_done) begin
                    issue = 1'b1;
                    if (bit_cnt == last_cnt) begin
                        cnt_n = 4'd0;
                        case (state)
                            touch_pkg::SLAVE_ADDR_WR: state_n = touch_pkg::REG_ADDR;
                            touch_pkg::REG_ADDR:      state_n = touch_pkg::STOP_WR;
                            touch_pkg::SLAVE_ADDR_RD: state_n = touch_pkg::READ_BYTE;
                            default:                  state_n = touch_pkg::MASTER_NACK;
                        endcase
                    end else begin
                        cnt_n = bit_cnt + 4'd1;
                    end
                end
            end
            default: begin
                // Single-command states
                if (bit_done) begin
                    issue = 1'b1;
                    case (state)
                        touch_pkg::START_WR:    state_n = touch_pkg::SLAVE_ADDR_WR;
                        touch_pkg::STOP_WR:     state_n = touch_pkg::START_RD;
                        touch_pkg::START_RD:    state_n = touch_pkg::SLAVE_ADDR_RD;
                        default:                state_n = touch_pkg::STOP_RD;
                    endcase
                end
            end
        endcase
    end

    always_comb begin : command_select
        case (state_n)
            touch_pkg::SLAVE_ADDR_WR: tx_byte = {touch_pkg::SLAVE_ADDR, 1'b0};
            touch_pkg::SLAVE_ADDR_RD: tx_byte = {touch_pkg::SLAVE_ADDR, 1'b1};
            default:                  tx_byte = reg_n;
        endcase
        bit_n = 1'b1;   // Released line unless a data bit is sent
        case (state_n)
            touch_pkg::START_WR, touch_pkg::START_RD: cmd_n = touch_pkg::CMD_START;
            touch_pkg::STOP_WR, touch_pkg::STOP_RD:   cmd_n = touch_pkg::CMD_STOP;
            touch_pkg::READ_BYTE:                     cmd_n = touch_pkg::CMD_READ;
            touch_pkg::MASTER_NACK:                   cmd_n = touch_pkg::CMD_WRITE;
            default: begin
                if (cnt_n < 4'd8) begin
                    cmd_n = touch_pkg::CMD_WRITE;
                    bit_n = tx_byte[3'(4'd7 - cnt_n)];   // MSB first
                end else begin
                    cmd_n = touch_pkg::CMD_READ;         // Slave ack, not checked
                end
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= touch_pkg::IDLE;
            bit_cnt    <= 4'd0;
            reg_addr   <= touch_pkg::XH;
            take       <= 1'b0;
            cmd_strobe <= 1'b0;
            done       <= 1'b0;
            data_out   <= 32'd0;
        end else begin
            state      <= state_n;
            bit_cnt    <= cnt_n;
            reg_addr   <= reg_n;
            take       <= (state == touch_pkg::IDLE) && pending;
            cmd_strobe <= issue;
            done       <= finish;
            if (finish) begin
                data_out <= shadow;
            end
        end
    end

    always_ff @(posedge clk) begin
        cmd    <= cmd_n;
        wr_bit <= bit_n;
        if (bit_done && state == touch_pkg::READ_BYTE) begin
            shadow[{lane, 3'(4'd7 - bit_cnt)}] <= rd_bit;
        end
    end

endmodule

// ==== hw/touch_irq_detect.sv ====
module touch_irq_detect (
    input  logic clk,
    input  logic nRst,
    input  logic inter,
    input  logic sda_in,
    input  logic take,
    output logic pending,
    output logic sda_sync
);

    logic inter_meta;
    logic inter_sync;
    logic inter_prev;
    logic sda_meta;
    logic irq_edge;

    // Both lines idle high, so the synchronizers reset to 1
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            inter_meta <= 1'b1;
            inter_sync <= 1'b1;
            inter_prev <= 1'b1;
            sda_meta   <= 1'b1;
            sda_sync   <= 1'b1;
        end else begin
            inter_meta <= inter;
            inter_sync <= inter_meta;
            inter_prev <= inter_sync;
            sda_meta   <= sda_in;
            sda_sync   <= sda_meta;
        end
    end

    assign irq_edge = inter_prev && !inter_sync;   // Active-low interrupt asserted

    // A new edge beats take, so a touch during a frame stays queued
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pending <= 1'b0;
        end else if (irq_edge) begin
            pending <= 1'b1;
        end else if (take) begin
            pending <= 1'b0;
        end
    end

endmodule

// ==== hw/touch_pkg.sv ====
package touch_pkg;

    // One transfer on the I2C wires, three clk phases each
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_t;

    typedef enum logic [3:0] {
        IDLE,
        START_WR,
        SLAVE_ADDR_WR,   // 7-bit address, write flag, ack slot
        REG_ADDR,        // Register pointer, ack slot
        STOP_WR,
        START_RD,
        SLAVE_ADDR_RD,   // 7-bit address, read flag, ack slot
        READ_BYTE,
        MASTER_NACK,
        STOP_RD
    } seq_state_t;

    // Coordinate registers of the touch controller
    typedef enum logic [7:0] {
        XH = 8'h03,
        XL = 8'h04,
        YH = 8'h05,
        YL = 8'h06
    } reg_addr_t;

    localparam logic [6:0] SLAVE_ADDR = 7'h38;

    localparam int PHASES_PER_BIT = 3;   // clk cycles per bus command

    // 40 commands per register transaction, four registers per frame
    localparam int CMDS_PER_REG   = 40;
    localparam int CMDS_PER_FRAME = 4 * CMDS_PER_REG;

endpackage
